// File: rtl/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

`default_nettype none

// instruction word width, fixed by the base ISA
`define RV_ILEN 32

// immediate and data width, 32 for RV32 and 64 for RV64
`define RV_XLEN 32

`default_nettype wire

`endif

// File: rtl/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    // base opcode groups, bits [6:0] of the word
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_FENCE  = 7'b0001111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_t;

    // FMT_NONE also covers FENCE, SYSTEM and unknown opcodes
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } rv_format_t;

    // one instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

endpackage

`default_nettype wire

// File: rtl/rv_id_format.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_format
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  rv_inst_u   in_inst,
    output logic       s1_valid,
    output rv_inst_u   s1_inst,
    output rv_format_t s1_format,
    output logic       s1_illegal
);

    rv_format_t fmt_next;
    logic       illegal_next;

    // opcode group to encoding format
    always_comb begin
        fmt_next     = FMT_NONE;
        illegal_next = 1'b0;
        case (in_inst.r.opcode)
            OPC_OP:     fmt_next = FMT_R;
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: fmt_next = FMT_I;
            OPC_STORE:  fmt_next = FMT_S;
            OPC_BRANCH: fmt_next = FMT_B;
            OPC_LUI,
            OPC_AUIPC:  fmt_next = FMT_U;
            OPC_JAL:    fmt_next = FMT_J;
            OPC_FENCE,
            OPC_SYSTEM: fmt_next = FMT_NONE;
            default: begin
                fmt_next     = FMT_NONE;
                illegal_next = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s1_format  <= FMT_NONE;
            s1_illegal <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            if (in_valid) begin
                s1_format  <= fmt_next;
                s1_illegal <= illegal_next;
            end
        end
    end

    // the word itself travels on to the immediate stage
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_inst <= in_inst;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_id_imm.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module rv_id_imm
    import rv_decode_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                s1_valid,
    input  rv_inst_u            s1_inst,
    input  rv_format_t          s1_format,
    input  logic                s1_illegal,
    output logic                s2_valid,
    output rv_inst_u            s2_inst,
    output rv_format_t          s2_format,
    output logic                s2_illegal,
    output logic [`RV_XLEN-1:0] s2_imm
);

    localparam int ILEN = `RV_ILEN;
    localparam int XLEN = `RV_XLEN;

    // immediate at instruction width, already signed from bit 31
    logic [ILEN-1:0] imm_raw;
    logic [XLEN-1:0] imm_next;

    always_comb begin
        case (s1_format)
            FMT_I: imm_raw = {{(ILEN-12){s1_inst.i.imm_11_0[11]}}, s1_inst.i.imm_11_0};
            FMT_S: imm_raw = {{(ILEN-12){s1_inst.s.imm_11_5[6]}},
                              s1_inst.s.imm_11_5, s1_inst.s.imm_4_0};
            FMT_B: imm_raw = {{(ILEN-13){s1_inst.b.imm_12}},
                              s1_inst.b.imm_12, s1_inst.b.imm_11,
                              s1_inst.b.imm_10_5, s1_inst.b.imm_4_1, 1'b0};
            FMT_J: imm_raw = {{(ILEN-21){s1_inst.j.imm_20}},
                              s1_inst.j.imm_20, s1_inst.j.imm_19_12,
                              s1_inst.j.imm_11, s1_inst.j.imm_10_1, 1'b0};
            FMT_U: imm_raw = {s1_inst.u.imm_31_12, 12'b0};
            // R and NONE carry no immediate
            default: imm_raw = '0;
        endcase
    end

    // widen to the data width, repeats bit 31 for a 64-bit build
    assign imm_next = XLEN'(signed'(imm_raw));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid   <= 1'b0;
            s2_format  <= FMT_NONE;
            s2_illegal <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            if (s1_valid) begin
                s2_format  <= s1_format;
                s2_illegal <= s1_illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_inst <= s1_inst;
            s2_imm  <= imm_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_id_regs.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module rv_id_regs
    import rv_decode_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                s2_valid,
    input  rv_inst_u            s2_inst,
    input  rv_format_t          s2_format,
    input  logic                s2_illegal,
    input  logic [`RV_XLEN-1:0] s2_imm,
    output logic                out_valid,
    output rv_format_t          out_format,
    output logic                out_illegal,
    output logic [`RV_XLEN-1:0] out_imm,
    output logic [4:0]          out_rd,
    output logic [4:0]          out_rs1,
    output logic [4:0]          out_rs2,
    output logic                out_rd_we
);

    logic use_rs1;
    logic use_rs2;
    logic use_rd;

    // register fields sit at the same bits in every format
    assign use_rs2 = (s2_format inside {FMT_R, FMT_S, FMT_B});
    assign use_rs1 = (s2_format inside {FMT_R, FMT_I, FMT_S, FMT_B});
    assign use_rd  = (s2_format inside {FMT_R, FMT_I, FMT_U, FMT_J});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_format  <= FMT_NONE;
            out_illegal <= 1'b0;
            out_rd_we   <= 1'b0;
        end else begin
            out_valid <= s2_valid;
            if (s2_valid) begin
                out_format  <= s2_format;
                out_illegal <= s2_illegal;
                // x0 is never a real write
                out_rd_we   <= use_rd && (s2_inst.r.rd != 5'd0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            out_imm <= s2_imm;
            out_rd  <= use_rd  ? s2_inst.r.rd  : 5'd0;
            out_rs1 <= use_rs1 ? s2_inst.r.rs1 : 5'd0;
            out_rs2 <= use_rs2 ? s2_inst.r.rs2 : 5'd0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_decode_top.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  rv_inst_u            in_inst,
    output logic                out_valid,
    output rv_format_t          out_format,
    output logic                out_illegal,
    output logic [`RV_XLEN-1:0] out_imm,
    output logic [4:0]          out_rd,
    output logic [4:0]          out_rs1,
    output logic [4:0]          out_rs2,
    output logic                out_rd_we
);

    // stage one to stage two
    logic       s1_valid;
    rv_inst_u   s1_inst;
    rv_format_t s1_format;
    logic       s1_illegal;

    // stage two to stage three
    logic                s2_valid;
    rv_inst_u            s2_inst;
    rv_format_t          s2_format;
    logic                s2_illegal;
    logic [`RV_XLEN-1:0] s2_imm;

    rv_id_format format_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .s1_valid   (s1_valid),
        .s1_inst    (s1_inst),
        .s1_format  (s1_format),
        .s1_illegal (s1_illegal)
    );

    rv_id_imm imm_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .s1_valid   (s1_valid),
        .s1_inst    (s1_inst),
        .s1_format  (s1_format),
        .s1_illegal (s1_illegal),
        .s2_valid   (s2_valid),
        .s2_inst    (s2_inst),
        .s2_format  (s2_format),
        .s2_illegal (s2_illegal),
        .s2_imm     (s2_imm)
    );

    rv_id_regs regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .s2_valid    (s2_valid),
        .s2_inst     (s2_inst),
        .s2_format   (s2_format),
        .s2_illegal  (s2_illegal),
        .s2_imm      (s2_imm),
        .out_valid   (out_valid),
        .out_format  (out_format),
        .out_illegal (out_illegal),
        .out_imm     (out_imm),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rd_we   (out_rd_we)
    );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tests/rv_decode_props.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module rv_decode_props
    import rv_decode_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                in_valid,
    input logic                out_valid,
    input rv_format_t          out_format,
    input logic                out_illegal,
    input logic [`RV_XLEN-1:0] out_imm,
    input logic [4:0]          out_rd,
    input logic                out_rd_we
);

    // three register stages between input and output
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##3 out_valid)
        else $error("out_valid did not follow in_valid after three cycles");

    no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 3))
        else $error("out_valid without an instruction three cycles earlier");

    rd_we_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        out_rd_we |-> (out_rd != 5'd0))
        else $error("register write enabled for x0");

    illegal_is_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_illegal) |-> (out_format == FMT_NONE && out_imm == '0))
        else $error("illegal word with a format or an immediate");

endmodule

bind rv_decode_top rv_decode_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .out_valid   (out_valid),
    .out_format  (out_format),
    .out_illegal (out_illegal),
    .out_imm     (out_imm),
    .out_rd      (out_rd),
    .out_rd_we   (out_rd_we)
);

`default_nettype wire

// File: tests/rv_decode_tb.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"
`default_nettype none

module rv_decode_tb
    import rv_decode_pkg::*;
();

    localparam int NUM_INST = 2000;

    typedef struct packed {
        rv_format_t          fmt;
        logic                illegal;
        logic [`RV_XLEN-1:0] imm;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic                rd_we;
    } expect_t;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    rv_inst_u            in_inst;
    logic                out_valid;
    rv_format_t          out_format;
    logic                out_illegal;
    logic [`RV_XLEN-1:0] out_imm;
    logic [4:0]          out_rd;
    logic [4:0]          out_rs1;
    logic [4:0]          out_rs2;
    logic                out_rd_we;

    expect_t    exp_q[$];
    integer     seed;
    int         sent;
    int         checked;
    logic [6:0] opcodes [0:10];

    tb_clk_gen clk_gen_i (.clk(clk));

    rv_decode_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .out_valid   (out_valid),
        .out_format  (out_format),
        .out_illegal (out_illegal),
        .out_imm     (out_imm),
        .out_rd      (out_rd),
        .out_rs1     (out_rs1),
        .out_rs2     (out_rs2),
        .out_rd_we   (out_rd_we)
    );

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // reference decode, bit positions taken from the base ISA encodings
    function automatic expect_t decode_model(input logic [31:0] w);
        expect_t     e;
        logic [31:0] imm32;
        logic [63:0] imm_wide;
        logic        uses_rd;
        logic        uses_rs1;
        logic        uses_rs2;
        e.illegal = 1'b0;
        case (w[6:0])
            7'b0110011: e.fmt = FMT_R;
            7'b1100111, 7'b0000011, 7'b0010011: e.fmt = FMT_I;
            7'b0100011: e.fmt = FMT_S;
            7'b1100011: e.fmt = FMT_B;
            7'b0110111, 7'b0010111: e.fmt = FMT_U;
            7'b1101111: e.fmt = FMT_J;
            7'b0001111, 7'b1110011: e.fmt = FMT_NONE;
            default: begin
                e.fmt     = FMT_NONE;
                e.illegal = 1'b1;
            end
        endcase
        case (e.fmt)
            FMT_I: imm32 = {{20{w[31]}}, w[31:20]};
            FMT_S: imm32 = {{20{w[31]}}, w[31:25], w[11:7]};
            FMT_B: imm32 = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            FMT_U: imm32 = {w[31:12], 12'd0};
            FMT_J: imm32 = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: imm32 = 32'd0;
        endcase
        imm_wide = {{32{imm32[31]}}, imm32};
        e.imm    = imm_wide[`RV_XLEN-1:0];
        uses_rs2 = (e.fmt == FMT_R) || (e.fmt == FMT_S) || (e.fmt == FMT_B);
        uses_rs1 = uses_rs2 || (e.fmt == FMT_I);
        uses_rd  = (e.fmt == FMT_R) || (e.fmt == FMT_I) || (e.fmt == FMT_U) ||
                   (e.fmt == FMT_J);
        e.rd     = uses_rd ? w[11:7] : 5'd0;
        e.rs1    = uses_rs1 ? w[19:15] : 5'd0;
        e.rs2    = uses_rs2 ? w[24:20] : 5'd0;
        e.rd_we  = uses_rd && (w[11:7] != 5'd0);
        return e;
    endfunction

    task automatic check_format(input rv_format_t got_fmt, input logic got_ill,
                                input rv_format_t exp_fmt, input logic exp_ill);
        if (got_fmt !== exp_fmt || got_ill !== exp_ill) begin
            $display("FAIL at %0t: format %s illegal %b, expected %s illegal %b",
                     $time, got_fmt.name(), got_ill, exp_fmt.name(), exp_ill);
            stop_run();
        end
    endtask

    task automatic check_imm(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: immediate %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_regs(input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic we, input expect_t e);
        if (rd !== e.rd || rs1 !== e.rs1 || rs2 !== e.rs2 || we !== e.rd_we) begin
            $display("FAIL at %0t: rd %0d rs1 %0d rs2 %0d we %b, expected %0d %0d %0d %b",
                     $time, rd, rs1, rs2, we, e.rd, e.rs1, e.rs2, e.rd_we);
            stop_run();
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        expect_t e;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid went high with no instruction in flight");
                stop_run();
            end else begin
                e = exp_q.pop_front();
                check_format(out_format, out_illegal, e.fmt, e.illegal);
                check_imm(out_imm, e.imm);
                check_regs(out_rd, out_rs1, out_rs2, out_rd_we, e);
                checked++;
            end
        end else if (checked == 0 && out_rd_we) begin
            $display("register write enable high before the first instruction");
            stop_run();
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        int          cycles;
        int          drain;
        seed     = 32'h0e8938a3;
        sent     = 0;
        checked  = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_inst  = '0;
        opcodes  = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                     7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b0001111,
                     7'b1110011};
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        cycles = 0;
        while (sent < NUM_INST && cycles < 20 * NUM_INST) begin
            @(posedge clk);
            cycles++;
            word = $random(seed);
            r    = $random(seed);
            // most words get a known opcode, the rest stay random
            if (r[3:0] != 4'd0) begin
                word[6:0] = opcodes[r[7:4] % 4'd11];
            end
            if (r[9:8] != 2'd0) begin
                in_valid <= 1'b1;
                in_inst  <= word;
                exp_q.push_back(decode_model(word));
                sent++;
            end else begin
                in_valid <= 1'b0;
                in_inst  <= $random(seed);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        if (sent != NUM_INST) begin
            $display("stimulus loop ran out of cycles after %0d instructions", sent);
            stop_run();
        end

        drain = 0;
        while (exp_q.size() != 0 && drain < 20) begin
            @(posedge clk);
            drain++;
        end
        // idle cycles so that a stray out_valid still reaches the monitor
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || checked != sent) begin
            $display("pipeline did not drain, %0d sent and %0d checked", sent, checked);
            stop_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/rv_id_format.sv
rtl/rv_id_imm.sv
rtl/rv_id_regs.sv
rtl/rv_decode_top.sv
tests/tb_clk_gen.sv
tests/rv_decode_props.sv
tests/rv_decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_decode_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
